// File: common/dmaRegPkg.sv
`default_nettype none

package dmaRegPkg;

  // byte offsets inside one channel's register block
  localparam int unsigned SadOffset = 0;
  localparam int unsigned DadOffset = 4;
  localparam int unsigned CntOffset = 8;
  localparam int unsigned ChannelStride = 12;

  localparam int unsigned CountBits = 14; // count of 0 means 16384 units

  // control fields in the upper half of CNT
  localparam int unsigned DestCtlPos = 21;
  localparam int unsigned SrcCtlPos = 23;
  localparam int unsigned RepeatBit = 25;
  localparam int unsigned WordBit = 26;
  localparam int unsigned TimingPos = 28;
  localparam int unsigned IrqBit = 30;
  localparam int unsigned EnableBit = 31;

  typedef enum logic [1:0] {
    stepIncrement = 2'd0,
    stepDecrement = 2'd1,
    stepFixed = 2'd2,
    stepIncReload = 2'd3 // dest goes back to DAD on every repeat
  } addrStepT;

  typedef enum logic [1:0] {
    timingImmediate = 2'd0,
    timingVblank = 2'd1,
    timingHblank = 2'd2,
    timingNever = 2'd3
  } startTimingT;

  localparam logic [7:0] VblankLine = 8'd160;
  localparam logic [7:0] HblankDot = 8'd240;

endpackage

`default_nettype wire

// File: common/dmaBusPkg.sv
`default_nettype none

package dmaBusPkg;

  typedef logic [31:0] dmaWordT;
  typedef logic [31:0] dmaAddrT;

  typedef logic [7:0] ioAddrT; // byte address into the register block

  // matches the memory bus size encoding
  typedef enum logic [1:0] {
    sizeHalf = 2'd1,
    sizeWord = 2'd2
  } accessSizeT;

  typedef logic [7:0] lineCountT;

endpackage

`default_nettype wire

// File: dmaChannel/dmaAddrPath.sv
`default_nettype none

module dmaAddrPath import dmaRegPkg::*, dmaBusPkg::*; (
  input  logic                 clk,
  input  logic                 rst_b,
  input  dmaWordT              sad,
  input  dmaWordT              dad,
  input  logic [CountBits-1:0] count,
  input  addrStepT             srcCtl,
  input  addrStepT             destCtl,
  input  logic                 wordSize,
  input  logic                 loadAll,
  input  logic                 reloadCount,
  input  logic                 stepSrc,
  input  logic                 stepDest,
  input  logic                 storeRdata,
  input  logic                 write,
  input  dmaWordT              memRdata,
  output logic                 unitsDone,
  output dmaAddrT              reqAddr,
  output accessSizeT           reqSize,
  output dmaWordT              reqWdata
);

  localparam logic [CountBits:0] MaxUnits = {1'b1, {CountBits{1'b0}}};

  dmaAddrT srcAddr, destAddr;
  dmaAddrT stepSize;
  dmaWordT dataLatch;
  logic [CountBits:0] unitsLeft;
  logic [CountBits:0] loadCount;

  function automatic dmaAddrT stepAddr(input dmaAddrT addr, input addrStepT ctl,
                                       input dmaAddrT amount);
    case (ctl)
      stepDecrement: return addr - amount;
      stepFixed: return addr;
      default: return addr + amount; // incReload steps up like increment
    endcase
  endfunction

  assign stepSize = wordSize ? dmaAddrT'(4) : dmaAddrT'(2);
  assign loadCount = (count == '0) ? MaxUnits : {1'b0, count};

  always_ff @(posedge clk) begin
    if (loadAll) srcAddr <= sad;
    else if (stepSrc) srcAddr <= stepAddr(srcAddr, srcCtl, stepSize);
  end

  always_ff @(posedge clk) begin
    if (loadAll || (reloadCount && destCtl == stepIncReload)) destAddr <= dad;
    else if (stepDest) destAddr <= stepAddr(destAddr, destCtl, stepSize);
  end

  // halfword reads land in the low half
  always_ff @(posedge clk) begin
    if (storeRdata) begin
      if (wordSize) dataLatch <= memRdata;
      else dataLatch <= {16'h0, srcAddr[1] ? memRdata[31:16] : memRdata[15:0]};
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) unitsLeft <= '0;
    else if (loadAll || reloadCount) unitsLeft <= loadCount;
    else if (stepDest) unitsLeft <= unitsLeft - 1'b1;
  end

  assign unitsDone = unitsLeft == {{CountBits{1'b0}}, 1'b1};

  assign reqAddr = write ? destAddr : srcAddr;
  assign reqSize = wordSize ? sizeWord : sizeHalf;
  assign reqWdata = wordSize ? dataLatch : {dataLatch[15:0], dataLatch[15:0]}; // memory picks the half

endmodule

`default_nettype wire

// File: dmaChannel/dmaChannelFsm.sv
`default_nettype none

module dmaChannelFsm (
  input  logic clk,
  input  logic rst_b,
  input  logic enable,
  input  logic start,
  input  logic repeatMode,
  input  logic irqEnable,
  input  logic preempted,
  input  logic allowedToBegin,
  input  logic memWait,
  input  logic unitsDone,
  output logic loadAll,
  output logic reloadCount,
  output logic stepSrc,
  output logic stepDest,
  output logic storeRdata,
  output logic active,
  output logic write,
  output logic midUnit,
  output logic irq,
  output logic clearEnable
);

  typedef enum logic [2:0] {
    sOff, sIdle, sQueued, sRead, sWrite, sPreemptedRead
  } stateT;

  stateT state, nextState;
  logic canBegin;
  logic lastWriteDone;

  assign canBegin = !preempted && !memWait && allowedToBegin;
  assign lastWriteDone = (state == sWrite) && !memWait && unitsDone;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) state <= sOff;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    loadAll = 1'b0;
    reloadCount = 1'b0;
    stepSrc = 1'b0;
    stepDest = 1'b0;
    storeRdata = 1'b0;
    case (state)
      sOff: begin
        if (enable) begin
          loadAll = 1'b1;
          nextState = sIdle;
        end
      end
      sIdle: begin
        if (!enable) nextState = sOff;
        else if (start) nextState = canBegin ? sRead : sQueued;
      end
      sQueued, sPreemptedRead: begin
        if (!enable) nextState = sOff;
        else if (canBegin) nextState = sRead;
      end
      sRead: begin
        // a higher channel took the bus before our read completed
        if (preempted) nextState = sPreemptedRead;
        else if (!memWait) begin
          storeRdata = 1'b1;
          stepSrc = 1'b1;
          nextState = sWrite;
        end
      end
      sWrite: begin
        if (!memWait) begin
          stepDest = 1'b1;
          if (unitsDone) begin
            reloadCount = repeatMode;
            nextState = repeatMode ? sIdle : sOff;
          end else if (!enable) nextState = sOff;
          else nextState = sRead; // read state yields if someone higher starts now
        end
      end
      default: nextState = sOff;
    endcase
  end

  assign active = (state == sRead) || (state == sWrite);
  assign write = state == sWrite;
  // read finishing this edge or write still pending: keeps the pair together
  assign midUnit = ((state == sRead) && !memWait && !preempted) ||
                   ((state == sWrite) && memWait);
  assign irq = lastWriteDone && irqEnable;
  assign clearEnable = lastWriteDone && !repeatMode;

endmodule

`default_nettype wire

// File: dmaChannel/dmaChannel.sv
`default_nettype none

module dmaChannel import dmaRegPkg::*, dmaBusPkg::*; (
  input  logic       clk,
  input  logic       rst_b,
  input  dmaWordT    sad,
  input  dmaWordT    dad,
  input  dmaWordT    cnt,
  input  lineCountT  vcount,
  input  lineCountT  hcount,
  input  logic       cpuPreemptable,
  input  logic       preempted,
  input  logic       allowedToBegin,
  input  dmaWordT    memRdata,
  input  logic       memWait,
  output logic       active,
  output logic       midUnit,
  output dmaAddrT    reqAddr,
  output logic       reqWrite,
  output accessSizeT reqSize,
  output dmaWordT    reqWdata,
  output logic       irq,
  output logic       clearEnable
);

  addrStepT srcCtl, destCtl;
  startTimingT timing;
  logic wordSize, repeatMode, irqEnable, enable;
  logic start;
  logic unitsDone, loadAll, reloadCount;
  logic stepSrc, stepDest, storeRdata;

  assign destCtl = addrStepT'(cnt[DestCtlPos +: 2]);
  assign srcCtl = addrStepT'(cnt[SrcCtlPos +: 2]);
  assign repeatMode = cnt[RepeatBit];
  assign wordSize = cnt[WordBit];
  assign timing = startTimingT'(cnt[TimingPos +: 2]);
  assign irqEnable = cnt[IrqBit];
  assign enable = cnt[EnableBit];

  always_comb begin
    case (timing)
      timingImmediate: start = cpuPreemptable;
      timingVblank: start = cpuPreemptable && (vcount == VblankLine);
      timingHblank: start = cpuPreemptable && (hcount == HblankDot);
      default: start = 1'b0; // never
    endcase
  end

  dmaChannelFsm fsm (
    .clk, .rst_b, .enable, .start, .repeatMode, .irqEnable,
    .preempted, .allowedToBegin, .memWait, .unitsDone,
    .loadAll, .reloadCount, .stepSrc, .stepDest, .storeRdata,
    .active, .write(reqWrite), .midUnit, .irq, .clearEnable
  );

  dmaAddrPath addrPath (
    .clk, .rst_b, .sad, .dad, .count(cnt[CountBits-1:0]),
    .srcCtl, .destCtl, .wordSize,
    .loadAll, .reloadCount, .stepSrc, .stepDest, .storeRdata,
    .write(reqWrite), .memRdata,
    .unitsDone, .reqAddr, .reqSize, .reqWdata
  );

endmodule

`default_nettype wire

// File: hdl/dmaRegFile.sv
`default_nettype none

module dmaRegFile import dmaRegPkg::*, dmaBusPkg::*; #(
  parameter int numChannels = 4
) (
  input  logic                   clk,
  input  logic                   rst_b,
  input  ioAddrT                 ioAddr,
  input  logic                   ioWrite,
  input  dmaWordT                ioWdata,
  output dmaWordT                ioRdata,
  input  logic [numChannels-1:0] clearEnable,
  output dmaWordT                sad [numChannels],
  output dmaWordT                dad [numChannels],
  output dmaWordT                cnt [numChannels]
);

  function automatic ioAddrT regAddr(input int ch, input int offset);
    return ioAddrT'(ch * ChannelStride + offset);
  endfunction

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int ch = 0; ch < numChannels; ch++) begin
        sad[ch] <= '0;
        dad[ch] <= '0;
        cnt[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < numChannels; ch++) begin
        if (clearEnable[ch]) cnt[ch][EnableBit] <= 1'b0; // finished, software sees it off
        // host write comes last so it wins over the clear
        if (ioWrite && ioAddr == regAddr(ch, SadOffset)) sad[ch] <= ioWdata;
        if (ioWrite && ioAddr == regAddr(ch, DadOffset)) dad[ch] <= ioWdata;
        if (ioWrite && ioAddr == regAddr(ch, CntOffset)) cnt[ch] <= ioWdata;
      end
    end
  end

  // read-back, anything unmapped reads as zero
  always_comb begin
    ioRdata = '0;
    for (int ch = 0; ch < numChannels; ch++) begin
      if (ioAddr == regAddr(ch, SadOffset)) ioRdata = sad[ch];
      if (ioAddr == regAddr(ch, DadOffset)) ioRdata = dad[ch];
      if (ioAddr == regAddr(ch, CntOffset)) ioRdata = cnt[ch];
    end
  end

endmodule

`default_nettype wire

// File: hdl/dmaArbiter.sv
`default_nettype none

module dmaArbiter import dmaBusPkg::*; #(
  parameter int numChannels = 4
) (
  input  logic [numChannels-1:0] active,
  input  logic [numChannels-1:0] midUnit,
  input  dmaAddrT                reqAddr [numChannels],
  input  logic [numChannels-1:0] reqWrite,
  input  accessSizeT             reqSize [numChannels],
  input  dmaWordT                reqWdata [numChannels],
  output logic [numChannels-1:0] preempted,
  output logic                   allowedToBegin,
  output logic                   memActive,
  output dmaAddrT                memAddr,
  output logic                   memWrite,
  output accessSizeT             memSize,
  output dmaWordT                memWdata
);

  logic higherActive;

  // channel 0 has top priority
  always_comb begin
    higherActive = 1'b0;
    for (int ch = 0; ch < numChannels; ch++) begin
      preempted[ch] = higherActive;
      higherActive = higherActive | active[ch];
    end
  end

  assign allowedToBegin = ~|midUnit; // no new unit while a read/write pair is open
  assign memActive = |active;

  always_comb begin
    memAddr = '0;
    memWrite = 1'b0;
    memSize = sizeWord;
    memWdata = '0;
    for (int ch = numChannels - 1; ch >= 0; ch--) begin
      if (active[ch]) begin // lowest active index ends up owning the bus
        memAddr = reqAddr[ch];
        memWrite = reqWrite[ch];
        memSize = reqSize[ch];
        memWdata = reqWdata[ch];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/dmaTop.sv
`default_nettype none

module dmaTop import dmaBusPkg::*; #(
  parameter int numChannels = 4
) (
  input  logic                   clk,
  input  logic                   rst_b,
  input  ioAddrT                 ioAddr,
  input  logic                   ioWrite,
  input  dmaWordT                ioWdata,
  output dmaWordT                ioRdata,
  input  lineCountT              vcount,
  input  lineCountT              hcount,
  input  logic                   cpuPreemptable,
  output logic                   memActive,
  output dmaAddrT                memAddr,
  output logic                   memWrite,
  output accessSizeT             memSize,
  output dmaWordT                memWdata,
  input  dmaWordT                memRdata,
  input  logic                   memWait,
  output logic [numChannels-1:0] irq
);

  dmaWordT sad [numChannels];
  dmaWordT dad [numChannels];
  dmaWordT cnt [numChannels];
  logic [numChannels-1:0] clearEnable;

  logic [numChannels-1:0] active;
  logic [numChannels-1:0] midUnit;
  logic [numChannels-1:0] preempted;
  logic allowedToBegin;

  dmaAddrT reqAddr [numChannels];
  logic [numChannels-1:0] reqWrite;
  accessSizeT reqSize [numChannels];
  dmaWordT reqWdata [numChannels];

  dmaRegFile #(.numChannels(numChannels)) regFile (
    .clk, .rst_b, .ioAddr, .ioWrite, .ioWdata, .ioRdata,
    .clearEnable, .sad, .dad, .cnt
  );

  dmaArbiter #(.numChannels(numChannels)) arbiter (
    .active, .midUnit, .reqAddr, .reqWrite, .reqSize, .reqWdata,
    .preempted, .allowedToBegin,
    .memActive, .memAddr, .memWrite, .memSize, .memWdata
  );

  for (genvar ch = 0; ch < numChannels; ch++) begin : chanGen
    dmaChannel channel (
      .clk, .rst_b,
      .sad(sad[ch]), .dad(dad[ch]), .cnt(cnt[ch]),
      .vcount, .hcount, .cpuPreemptable,
      .preempted(preempted[ch]), .allowedToBegin,
      .memRdata, .memWait,
      .active(active[ch]), .midUnit(midUnit[ch]),
      .reqAddr(reqAddr[ch]), .reqWrite(reqWrite[ch]),
      .reqSize(reqSize[ch]), .reqWdata(reqWdata[ch]),
      .irq(irq[ch]), .clearEnable(clearEnable[ch])
    );
  end

endmodule

`default_nettype wire

// File: tb/dmaTbTests.svh
// host bus and memory helpers, then one task per directed test

task automatic writeReg(input ioAddrT addr, input dmaWordT data);
  @(posedge clk);
  #5;
  ioAddr = addr;
  ioWdata = data;
  ioWrite = 1'b1;
  @(posedge clk); // write lands here
  #5;
  ioWrite = 1'b0;
endtask

task automatic readReg(input ioAddrT addr, output dmaWordT data);
  @(posedge clk);
  #5;
  ioAddr = addr;
  ioWrite = 1'b0;
  #10;
  data = ioRdata;
endtask

task automatic fillMemory();
  for (int i = 0; i < MemWords; i++) expMem[memIndexT'(i)] = fillWord(i);
  @(posedge clk);
  #5;
  fillRequest = 1'b1;
  @(posedge clk);
  #5;
  fillRequest = 1'b0;
endtask

task automatic checkMemory(input string name);
  for (int i = 0; i < MemWords; i++)
    compareWord($sformatf("%s mem[%0d]", name, i), expMem[memIndexT'(i)], mem[memIndexT'(i)]);
endtask

task automatic expectCopy(input int srcIdx, input int dstIdx, input int units);
  for (int i = 0; i < units; i++) expMem[memIndexT'(dstIdx + i)] = fillWord(srcIdx + i);
endtask

task automatic waitAnyIrq(input string name, output irqVecT seen);
  int waited;
  waited = 0;
  seen = '0;
  while (seen == '0) begin
    @(posedge clk);
    #15;
    seen = irq;
    waited++;
    if (seen == '0 && waited >= IrqWaitLimit)
      stopWithFailure($sformatf("%s: no interrupt within %0d cycles", name, IrqWaitLimit));
  end
endtask

task automatic expectNoIrq(input string name, input int cycles);
  repeat (cycles) begin
    @(posedge clk);
    #15;
    compareIrq(name, '0, irq);
  end
endtask

function automatic dmaWordT cntWord(input int count, input addrStepT destCtl,
                                    input addrStepT srcCtl, input logic repeatOn,
                                    input logic wordOn, input startTimingT timing,
                                    input logic irqOn);
  dmaWordT w;
  w = '0;
  w[CountBits-1:0] = count[CountBits-1:0];
  w[DestCtlPos +: 2] = destCtl;
  w[SrcCtlPos +: 2] = srcCtl;
  w[RepeatBit] = repeatOn;
  w[WordBit] = wordOn;
  w[TimingPos +: 2] = timing;
  w[IrqBit] = irqOn;
  w[EnableBit] = 1'b1;
  return w;
endfunction

task automatic startChannel(input int ch, input dmaAddrT src, input dmaAddrT dst,
                            input dmaWordT cntValue);
  writeReg(chanRegAddr(ch, SadOffset), src);
  writeReg(chanRegAddr(ch, DadOffset), dst);
  writeReg(chanRegAddr(ch, CntOffset), cntValue);
endtask

function automatic dmaWordT regPattern(input int ch, input int offset);
  return dmaWordT'((ch * 16 + offset + 1) * 32'h0101_0731) & 32'h7fff_ffff; // enable stays off
endfunction

task automatic checkRegisterAccess();
  dmaWordT value;
  for (int ch = 0; ch < numChannels; ch++) begin
    for (int off = 0; off < ChannelStride; off += 4) begin
      readReg(chanRegAddr(ch, off), value);
      compareWord($sformatf("registerReset ch%0d+%0d", ch, off), '0, value);
    end
  end
  for (int ch = 0; ch < numChannels; ch++)
    for (int off = 0; off < ChannelStride; off += 4)
      writeReg(chanRegAddr(ch, off), regPattern(ch, off));
  for (int ch = 0; ch < numChannels; ch++) begin
    for (int off = 0; off < ChannelStride; off += 4) begin
      readReg(chanRegAddr(ch, off), value);
      compareWord($sformatf("registerReadBack ch%0d+%0d", ch, off), regPattern(ch, off), value);
    end
  end
  readReg(8'h30, value); // first byte past channel 3
  compareWord("registerUnmapped 30", '0, value);
  readReg(8'hff, value);
  compareWord("registerUnmapped ff", '0, value);
endtask

task automatic copyWordBlock();
  dmaWordT cntValue;
  dmaWordT readBack;
  irqVecT seen;
  fillMemory();
  expectCopy(64, 256, 8);
  cntValue = cntWord(8, stepIncrement, stepIncrement, 1'b0, 1'b1, timingImmediate, 1'b1);
  startChannel(0, 32'h100, 32'h400, cntValue);
  waitAnyIrq("wordCopy", seen);
  compareIrq("wordCopy irq", oneHot(0), seen);
  expectNoIrq("wordCopy single irq", 20);
  readReg(chanRegAddr(0, CntOffset), readBack);
  cntValue[EnableBit] = 1'b0;
  compareWord("wordCopy cnt", cntValue, readBack);
  checkMemory("wordCopy");
endtask

task automatic copyHalfwordsFixedDest();
  dmaWordT cntValue;
  dmaWordT readBack;
  dmaWordT srcWord;
  dmaWordT destWord;
  irqVecT seen;
  randomWaits = 1'b1;
  fillMemory();
  // source steps down from 0x20a so the last read is the low half of word 0x200
  srcWord = fillWord(128);
  destWord = fillWord(320);
  expMem[320] = {srcWord[15:0], destWord[15:0]}; // 0x502 is the upper half
  cntValue = cntWord(6, stepFixed, stepDecrement, 1'b0, 1'b0, timingImmediate, 1'b1);
  startChannel(1, 32'h20a, 32'h502, cntValue);
  waitAnyIrq("halfwordFixedDest", seen);
  randomWaits = 1'b0;
  compareIrq("halfwordFixedDest irq", oneHot(1), seen);
  expectNoIrq("halfwordFixedDest single irq", 10);
  readReg(chanRegAddr(1, CntOffset), readBack);
  cntValue[EnableBit] = 1'b0;
  compareWord("halfwordFixedDest cnt", cntValue, readBack);
  checkMemory("halfwordFixedDest");
endtask

task automatic repeatOnVblank();
  dmaWordT cntValue;
  dmaWordT readBack;
  irqVecT seen;
  fillMemory();
  cntValue = cntWord(4, stepIncReload, stepIncrement, 1'b1, 1'b1, timingVblank, 1'b1);
  startChannel(2, 32'h300, 32'h600, cntValue);
  expectNoIrq("vblankRepeat before blank", 30);
  checkMemory("vblankRepeat before blank");
  for (int pass = 0; pass < 2; pass++) begin
    expectCopy(192 + pass * 4, 384, 4); // source keeps going, destination reloads
    @(posedge clk);
    #5;
    vcount = VblankLine;
    @(posedge clk);
    #5;
    vcount = '0;
    waitAnyIrq("vblankRepeat", seen);
    compareIrq("vblankRepeat irq", oneHot(2), seen);
    expectNoIrq("vblankRepeat single irq", 10);
    checkMemory($sformatf("vblankRepeat pass%0d", pass));
  end
  readReg(chanRegAddr(2, CntOffset), readBack);
  compareWord("vblankRepeat cnt", cntValue, readBack);
  writeReg(chanRegAddr(2, CntOffset), '0);
endtask

task automatic preemptLowerChannel();
  dmaWordT cntValue;
  irqVecT seen;
  fillMemory();
  expectCopy(64, 288, 8);
  expectCopy(96, 352, 8);
  cntValue = cntWord(8, stepIncrement, stepIncrement, 1'b0, 1'b1, timingImmediate, 1'b1);
  writeReg(chanRegAddr(0, SadOffset), 32'h100);
  writeReg(chanRegAddr(0, DadOffset), 32'h480);
  writeReg(chanRegAddr(3, SadOffset), 32'h180);
  writeReg(chanRegAddr(3, DadOffset), 32'h580);
  // channel 3 gets going first, channel 0 has to take over between its units
  writeReg(chanRegAddr(3, CntOffset), cntValue);
  writeReg(chanRegAddr(0, CntOffset), cntValue);
  waitAnyIrq("priority first", seen);
  compareIrq("priority first irq", oneHot(0), seen);
  waitAnyIrq("priority second", seen);
  compareIrq("priority second irq", oneHot(3), seen);
  expectNoIrq("priority quiet", 10);
  checkMemory("priority");
endtask

task automatic holdUntilHblankPreemptable();
  dmaWordT cntValue;
  irqVecT seen;
  fillMemory();
  cpuPreemptable = 1'b0;
  cntValue = cntWord(4, stepIncrement, stepIncrement, 1'b0, 1'b1, timingHblank, 1'b1);
  startChannel(1, 32'h080, 32'h680, cntValue);
  @(posedge clk);
  #5;
  hcount = HblankDot;
  expectNoIrq("hblank not preemptable", 20);
  checkMemory("hblank not preemptable");
  @(posedge clk);
  #5;
  hcount = '0;
  cpuPreemptable = 1'b1;
  expectNoIrq("hblank outside blank", 5);
  expectCopy(32, 416, 4);
  @(posedge clk);
  #5;
  hcount = HblankDot;
  @(posedge clk);
  #5;
  hcount = '0;
  waitAnyIrq("hblank", seen);
  compareIrq("hblank irq", oneHot(1), seen);
  expectNoIrq("hblank single irq", 10);
  checkMemory("hblank");
endtask

// File: tb/dmaTb.sv
`default_nettype none

module dmaTb import dmaRegPkg::*, dmaBusPkg::*; ();

  localparam int numChannels = 4;
  localparam int MemWords = 1024;
  localparam int IrqWaitLimit = 2000;
  // six tests of up to 64 units, two accesses each with up to 4 waits, plus setup
  localparam int WatchdogCycles = 20000;

  typedef logic [numChannels-1:0] irqVecT;
  typedef logic [9:0] memIndexT;

  logic clk = 1'b0;
  logic rst_b;
  ioAddrT ioAddr;
  logic ioWrite;
  dmaWordT ioWdata;
  dmaWordT ioRdata;
  lineCountT vcount;
  lineCountT hcount;
  logic cpuPreemptable;
  logic memActive;
  dmaAddrT memAddr;
  logic memWrite;
  accessSizeT memSize;
  dmaWordT memWdata;
  dmaWordT memRdata;
  logic memWait;
  irqVecT irq;

  dmaWordT mem [MemWords];
  dmaWordT expMem [MemWords]; // what memory should hold after the current test
  logic fillRequest;
  logic randomWaits;

  always #20 clk = ~clk;

  dmaTop #(.numChannels(numChannels)) u_dut (
    .clk, .rst_b, .ioAddr, .ioWrite, .ioWdata, .ioRdata,
    .vcount, .hcount, .cpuPreemptable,
    .memActive, .memAddr, .memWrite, .memSize, .memWdata,
    .memRdata, .memWait, .irq
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // odd multiplier keeps every word of the array distinct
  function automatic dmaWordT fillWord(input int idx);
    return (dmaWordT'(idx) * 32'h045d_9f3b) ^ 32'hc0de_5a5a;
  endfunction

  function automatic ioAddrT chanRegAddr(input int ch, input int offset);
    return ioAddrT'(ch * ChannelStride + offset);
  endfunction

  function automatic irqVecT oneHot(input int ch);
    return irqVecT'(1) << ch;
  endfunction

  assign memRdata = mem[memAddr[11:2]]; // the DUT selects the half on halfword reads

  always @(posedge clk) begin
    if (fillRequest) begin
      for (int i = 0; i < MemWords; i++) mem[memIndexT'(i)] <= fillWord(i);
    end else if (memActive && memWrite && !memWait) begin
      if (memSize == sizeWord) mem[memAddr[11:2]] <= memWdata;
      else if (memAddr[1]) mem[memAddr[11:2]][31:16] <= memWdata[31:16];
      else mem[memAddr[11:2]][15:0] <= memWdata[15:0];
    end
  end

  initial begin : waitGen
    logic [31:0] rngState;
    int waitRun;
    rngState = 32'd5;
    waitRun = 0;
    memWait = 1'b0;
    forever begin
      @(posedge clk);
      #5;
      rngState = xorshift(rngState);
      if (randomWaits && waitRun < 4 && rngState[7]) begin // at most 4 waits in a row
        memWait = 1'b1;
        waitRun++;
      end else begin
        memWait = 1'b0;
        waitRun = 0;
      end
    end
  end

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compareWord(input string name, input dmaWordT expected, input dmaWordT actual);
    if (actual !== expected)
      stopWithFailure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic compareIrq(input string name, input irqVecT expected, input irqVecT actual);
    if (actual !== expected)
      stopWithFailure($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    stopWithFailure("watchdog expired before the tests finished");
  end

  `include "dmaTbTests.svh"

  initial begin
    rst_b = 1'b0;
    ioAddr = '0;
    ioWrite = 1'b0;
    ioWdata = '0;
    vcount = '0;
    hcount = '0;
    cpuPreemptable = 1'b1;
    fillRequest = 1'b0;
    randomWaits = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    rst_b = 1'b1;
    checkRegisterAccess();
    copyWordBlock();
    copyHalfwordsFixedDest();
    repeatOnVblank();
    preemptLowerChannel();
    holdUntilHblankPreemptable();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
common/dmaRegPkg.sv
common/dmaBusPkg.sv
dmaChannel/dmaAddrPath.sv
dmaChannel/dmaChannelFsm.sv
dmaChannel/dmaChannel.sv
hdl/dmaRegFile.sv
hdl/dmaArbiter.sv
hdl/dmaTop.sv
tb/dmaTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
logFile=sim.log

if ! verilator --binary --timing -f project.f --top-module dmaTb -o dmaSim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dmaSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "TEST FAIL" "$logFile"; then
  exit 1
fi
if [ "$runStatus" -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi
exit 0
